//--- list.f
logic/sha512_pkg.sv
logic/sha512_csr.sv
logic/sha512_requestor.sv
logic/block_fifo.sv
logic/sha512_core.sv
logic/sha512_accel.sv
testbench/tb_wb_memory.sv
testbench/tb_sha512_accel.sv

//--- testbench/tb_sha512_accel.sv
`timescale 1ns/10ps

module tb_sha512_accel;

  import sha512_pkg::*;

  // ==============================
  // Constants
  // ==============================

  // Message locations in the memory model
  localparam int abc_addr  = 16'h0100;
  localparam int long_addr = 16'h0200;

  // Three jobs of four blocks in all take well under 200 cycles per block with polling
  localparam int max_cycles = 5000;

  // Published FIPS 180-4 digests with H0 in the top word
  localparam digest_t abc_digest = {
    64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
    64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd, 64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f
  };
  localparam digest_t long_digest = {
    64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1, 64'h7299aeadb6889018,
    64'h501d289e4900f7e4, 64'h331b99dec4b5433a, 64'hc7d329eeb6dd2654, 64'h5e96e55b874be909
  };

  logic        clk;
  logic        reset;
  logic        s_cyc;
  logic        s_stb;
  logic        s_we;
  logic [3:0]  s_adr;
  word_t       s_dat_w;
  logic        s_ack;
  word_t       s_dat_r;
  logic        m_cyc;
  logic        m_stb;
  logic [15:0] m_adr;
  logic        m_ack;
  word_t       m_dat_r;
  int          cycle_count = 0;
  word_t       rd;

  sha512_accel #(
    .addr_w     (16),
    .fifo_depth (2)
  ) dut0
  (
    .clk     (clk),
    .reset   (reset),
    .s_cyc   (s_cyc),
    .s_stb   (s_stb),
    .s_we    (s_we),
    .s_adr   (s_adr),
    .s_dat_w (s_dat_w),
    .s_ack   (s_ack),
    .s_dat_r (s_dat_r),
    .m_cyc   (m_cyc),
    .m_stb   (m_stb),
    .m_adr   (m_adr),
    .m_ack   (m_ack),
    .m_dat_r (m_dat_r)
  );

  // Message memory with random wait states
  tb_wb_memory #(
    .addr_w (16)
  ) mem0
  (
    .clk     (clk),
    .m_cyc   (m_cyc),
    .m_stb   (m_stb),
    .m_adr   (m_adr),
    .m_ack   (m_ack),
    .m_dat_r (m_dat_r)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  // ==============================
  // Failure handling and checks
  // ==============================

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
    else
      abort_run($sformatf("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual));
  endtask

  // Run limit in clock cycles
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == max_cycles)
      abort_run($sformatf("ERROR: timeout, no end of test after %0d cycles", max_cycles));
  end

  // Host slave acknowledges one cycle after a new request
  ack_follows_req: assert property (@(posedge clk) disable iff (reset)
    (s_cyc && s_stb && !s_ack) |=> s_ack)
    else abort_run("ERROR: s_ack did not follow a host request by one cycle");

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset) s_ack |=> !s_ack)
    else abort_run("ERROR: s_ack stayed high for more than one cycle");

  // Memory master keeps its strobe inside the cycle
  stb_inside_cyc: assert property (@(posedge clk) disable iff (reset) m_stb |-> m_cyc)
    else abort_run("ERROR: m_stb was high while m_cyc was low");

  // A waiting memory request holds strobe and address
  adr_held: assert property (@(posedge clk) disable iff (reset)
    (m_stb && !m_ack) |=> (m_stb && $stable(m_adr)))
    else abort_run("ERROR: m_adr or m_stb changed while waiting for m_ack");

  // ==============================
  // Host bus and job tasks
  // ==============================

  // Both bus tasks start and end 1 ns after a rising edge
  task automatic bus_write(input logic [3:0] adr, input word_t data);
    s_cyc   = 1'b1;
    s_stb   = 1'b1;
    s_we    = 1'b1;
    s_adr   = adr;
    s_dat_w = data;
    do
    begin
      @(posedge clk);
      #1;
    end
    while (s_ack !== 1'b1);
    s_cyc = 1'b0;
    s_stb = 1'b0;
    s_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] adr, output word_t data);
    s_cyc = 1'b1;
    s_stb = 1'b1;
    s_we  = 1'b0;
    s_adr = adr;
    do
    begin
      @(posedge clk);
      #1;
    end
    while (s_ack !== 1'b1);
    data  = s_dat_r;
    s_cyc = 1'b0;
    s_stb = 1'b0;
  endtask

  // Places the padded test messages with W0 of each block at the lowest address
  task automatic load_messages();
    word_t w;
    mem0.mem[abc_addr] = 64'h6162638000000000;
    for (int i = 1; i < 15; i++)
      mem0.mem[abc_addr + i] = '0;
    // Message length is 24 bits
    mem0.mem[abc_addr + 15] = 64'h18;
    // Word i of the long message is eight letters starting at 'a' plus i
    for (int i = 0; i < 14; i++)
    begin
      for (int j = 0; j < 8; j++)
        w[63 - 8 * j -: 8] = 8'h61 + 8'(i + j);
      mem0.mem[long_addr + i] = w;
    end
    mem0.mem[long_addr + 14] = 64'h8000000000000000;
    for (int i = 15; i < 31; i++)
      mem0.mem[long_addr + i] = '0;
    // Length of 896 bits closes the second block
    mem0.mem[long_addr + 31] = 64'h380;
  endtask

  task automatic run_job(input word_t src, input word_t count, input digest_t expected);
    word_t data;
    bus_write(csr_src_addr, src);
    bus_write(csr_block_count, count);
    bus_read(csr_src_addr, data);
    check_word("s_dat_r (src_addr)", src, data);
    bus_read(csr_block_count, data);
    check_word("s_dat_r (block_count)", count, data);
    bus_write(csr_ctrl, 64'h1);
    bus_read(csr_status, data);
    check_word("s_dat_r (status while running)", 64'h1, data);
    // The memory cycle closes once per block, after the last one only the core is busy
    for (int b = 0; b < count; b++)
    begin
      @(negedge m_cyc);
      #1;
    end
    // An accepted start here would fetch the message again and spoil the next job
    bus_write(csr_ctrl, 64'h1);
    do
      bus_read(csr_status, data);
    while (data[1] !== 1'b1);
    check_word("s_dat_r (status after job)", 64'h2, data);
    for (int i = 0; i < 8; i++)
    begin
      bus_read(csr_digest_base + 4'(i), data);
      check_word($sformatf("s_dat_r (digest word %0d)", i), expected[511 - 64 * i -: 64],
                 data);
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================

  initial
  begin
    reset   = 1'b1;
    s_cyc   = 1'b0;
    s_stb   = 1'b0;
    s_we    = 1'b0;
    s_adr   = '0;
    s_dat_w = '0;
    repeat (10)
      @(posedge clk);
    #1;
    reset = 1'b0;
    // Idle buses and cleared registers after reset
    check_word("s_ack", 64'h0, word_t'(s_ack));
    check_word("m_cyc", 64'h0, word_t'(m_cyc));
    bus_read(csr_status, rd);
    check_word("s_dat_r (status after reset)", 64'h0, rd);
    bus_read(csr_digest_base, rd);
    check_word("s_dat_r (digest word 0 after reset)", 64'h0, rd);
    load_messages();
    // One block, then two chained blocks, then the first message again
    run_job(abc_addr, 64'd1, abc_digest);
    run_job(long_addr, 64'd2, long_digest);
    run_job(abc_addr, 64'd1, abc_digest);
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- testbench/tb_wb_memory.sv
`timescale 1ns/10ps

module tb_wb_memory #(
  parameter int addr_w = 16
)
(
  input  logic              clk,
  // Wishbone classic slave side, read only
  input  logic              m_cyc,
  input  logic              m_stb,
  input  logic [addr_w-1:0] m_adr,
  output logic              m_ack,
  output sha512_pkg::word_t m_dat_r
);

  import sha512_pkg::*;

  // Whole address space of the master, one word per address
  word_t  mem [2**addr_w];
  integer seed;
  int     wait_cnt;
  logic   pending;

  initial
  begin
    seed     = 67;
    wait_cnt = 0;
    pending  = 1'b0;
    m_ack    = 1'b0;
    m_dat_r  = '0;
    // Background pattern, every word differs with its address
    for (int i = 0; i < 2**addr_w; i++)
      mem[i] = {32'(i), ~32'(i)};
    // Responses change a little after the clock edge, like the rest of the stimulus
    forever
    begin
      @(posedge clk);
      #1;
      if (m_ack)
        // The acknowledge lasts one cycle
        m_ack = 1'b0;
      else if (m_cyc && m_stb)
      begin
        // A new request draws its own number of wait states, 0 to 3
        if (!pending)
        begin
          pending  = 1'b1;
          wait_cnt = int'($random(seed) & 3);
        end
        if (wait_cnt == 0)
        begin
          m_ack   = 1'b1;
          m_dat_r = mem[m_adr];
          pending = 1'b0;
        end
        else
          wait_cnt = wait_cnt - 1;
      end
    end
  end

endmodule

//--- logic/sha512_accel.sv
`timescale 1ns/10ps

module sha512_accel #(
  parameter int addr_w     = 16,
  parameter int fifo_depth = 2
)
(
  input  logic              clk,
  input  logic              reset,
  // Host port, Wishbone classic slave
  input  logic              s_cyc,
  input  logic              s_stb,
  input  logic              s_we,
  input  logic [3:0]        s_adr,
  input  sha512_pkg::word_t s_dat_w,
  output logic              s_ack,
  output sha512_pkg::word_t s_dat_r,
  // Memory port, Wishbone classic master
  output logic              m_cyc,
  output logic              m_stb,
  output logic [addr_w-1:0] m_adr,
  input  logic              m_ack,
  input  sha512_pkg::word_t m_dat_r
);

  import sha512_pkg::*;

  // ==============================
  // Internal connections
  // ==============================

  logic              start;
  logic [addr_w-1:0] src_addr;
  logic [addr_w-1:0] block_count;
  logic              push;
  block_t            push_block;
  logic              push_first;
  logic              push_last;
  logic              full;
  logic              pop;
  logic              empty;
  block_t            head_block;
  logic              head_first;
  logic              head_last;
  digest_t           digest;
  logic              digest_valid;

  // ==============================
  // Instances
  // ==============================

  // Register file, job setup in and digest out
  sha512_csr #(
    .addr_w (addr_w)
  ) uu_sha512_csr
  (
    .clk          (clk),
    .reset        (reset),
    .s_cyc        (s_cyc),
    .s_stb        (s_stb),
    .s_we         (s_we),
    .s_adr        (s_adr),
    .s_dat_w      (s_dat_w),
    .s_ack        (s_ack),
    .s_dat_r      (s_dat_r),
    .start        (start),
    .src_addr     (src_addr),
    .block_count  (block_count),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

  // Producer, fetches message words and builds blocks
  sha512_requestor #(
    .addr_w (addr_w)
  ) uu_sha512_requestor
  (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .src_addr    (src_addr),
    .block_count (block_count),
    .m_cyc       (m_cyc),
    .m_stb       (m_stb),
    .m_adr       (m_adr),
    .m_ack       (m_ack),
    .m_dat_r     (m_dat_r),
    .push        (push),
    .push_block  (push_block),
    .push_first  (push_first),
    .push_last   (push_last),
    .full        (full)
  );

  // Buffer between fetch and hashing
  block_fifo #(
    .fifo_depth (fifo_depth)
  ) uu_block_fifo
  (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_block (push_block),
    .push_first (push_first),
    .push_last  (push_last),
    .full       (full),
    .pop        (pop),
    .empty      (empty),
    .head_block (head_block),
    .head_first (head_first),
    .head_last  (head_last)
  );

  // Consumer, one compression round per clock
  sha512_core uu_sha512_core
  (
    .clk          (clk),
    .reset        (reset),
    .empty        (empty),
    .pop          (pop),
    .head_block   (head_block),
    .head_first   (head_first),
    .head_last    (head_last),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

endmodule

//--- logic/sha512_core.sv
`timescale 1ns/10ps

module sha512_core
(
  input  logic                clk,
  input  logic                reset,
  // Block path from the FIFO
  input  logic                empty,
  output logic                pop,
  input  sha512_pkg::block_t  head_block,
  input  logic                head_first,
  input  logic                head_last,
  // Result towards the CSR block
  output sha512_pkg::digest_t digest,
  output logic                digest_valid
);

  import sha512_pkg::*;

  core_state_t state;
  logic [6:0]  round_cnt;
  logic        last_q;
  digest_t     hash_q;
  digest_t     chain_init;
  // Schedule window, w[0] is the word used in the current round
  word_t       w [16];
  // Working variables a to h
  word_t       v [8];
  word_t       big_s0;
  word_t       big_s1;
  word_t       ch;
  word_t       maj;
  word_t       t1;
  word_t       t2;
  word_t       w_next;

  function automatic word_t rotr(input word_t x, input int n);
    rotr = (x >> n) | (x << (64 - n));
  endfunction

  // ==============================
  // Round function
  // ==============================

  always_comb
  begin
    big_s1 = rotr(v[4], 14) ^ rotr(v[4], 18) ^ rotr(v[4], 41);
    ch     = (v[4] & v[5]) ^ (~v[4] & v[6]);
    t1     = v[7] + big_s1 + ch + k_table[round_cnt] + w[0];
    big_s0 = rotr(v[0], 28) ^ rotr(v[0], 34) ^ rotr(v[0], 39);
    maj    = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
    t2     = big_s0 + maj;
    // Message word sixteen rounds ahead, from the small sigma functions
    w_next = (rotr(w[14], 19) ^ rotr(w[14], 61) ^ (w[14] >> 6)) + w[9] +
             (rotr(w[1], 1) ^ rotr(w[1], 8) ^ (w[1] >> 7)) + w[0];
  end

  // A first block starts from the standard initial value
  assign chain_init = head_first ? h_init : hash_q;
  assign pop        = (state == core_idle) && !empty;
  assign digest     = hash_q;

  // ==============================
  // Control
  // ==============================

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state        <= core_idle;
      round_cnt    <= '0;
      last_q       <= 1'b0;
      digest_valid <= 1'b0;
    end
    else
    begin
      digest_valid <= 1'b0;
      case (state)
        core_idle:
          if (pop)
          begin
            round_cnt <= '0;
            last_q    <= head_last;
            state     <= core_round;
          end
        core_round:
        begin
          round_cnt <= round_cnt + 1'b1;
          if (round_cnt == 7'd79)
            state <= core_finish;
        end
        core_finish:
        begin
          // Only the end of a message is reported
          digest_valid <= last_q;
          state        <= core_idle;
        end
        default:
          state <= core_idle;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      for (int i = 0; i < 16; i++)
        w[i] <= head_block[1023 - 64 * i -: 64];
      for (int i = 0; i < 8; i++)
        v[i] <= chain_init[511 - 64 * i -: 64];
      hash_q <= chain_init;
    end
    else if (state == core_round)
    begin
      for (int i = 0; i < 15; i++)
        w[i] <= w[i + 1];
      w[15] <= w_next;
      v[0]  <= t1 + t2;
      v[1]  <= v[0];
      v[2]  <= v[1];
      v[3]  <= v[2];
      v[4]  <= v[3] + t1;
      v[5]  <= v[4];
      v[6]  <= v[5];
      v[7]  <= v[6];
    end
    else if (state == core_finish)
    begin
      // Fold the working variables into the chaining state
      for (int i = 0; i < 8; i++)
        hash_q[511 - 64 * i -: 64] <= hash_q[511 - 64 * i -: 64] + v[i];
    end
  end

endmodule

//--- logic/block_fifo.sv
`timescale 1ns/10ps

module block_fifo #(
  parameter int fifo_depth = 2
)
(
  input  logic               clk,
  input  logic               reset,
  // Write side, from the requestor
  input  logic               push,
  input  sha512_pkg::block_t push_block,
  input  logic               push_first,
  input  logic               push_last,
  output logic               full,
  // Read side, towards the core
  input  logic               pop,
  output logic               empty,
  output sha512_pkg::block_t head_block,
  output logic               head_first,
  output logic               head_last
);

  import sha512_pkg::*;

  // Depth is a power of two, so the index is the low pointer bits
  localparam int ptr_w = $clog2(fifo_depth);

  block_t         mem_block [fifo_depth];
  logic           mem_first [fifo_depth];
  logic           mem_last  [fifo_depth];
  logic [ptr_w:0] wr_ptr;
  logic [ptr_w:0] rd_ptr;

  // The extra top bit tells a full buffer from an empty one
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                 (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

  assign head_block = mem_block[rd_ptr[ptr_w-1:0]];
  assign head_first = mem_first[rd_ptr[ptr_w-1:0]];
  assign head_last  = mem_last[rd_ptr[ptr_w-1:0]];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Entry storage, the tags travel with their block
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem_block[wr_ptr[ptr_w-1:0]] <= push_block;
      mem_first[wr_ptr[ptr_w-1:0]] <= push_first;
      mem_last[wr_ptr[ptr_w-1:0]]  <= push_last;
    end
  end

endmodule

//--- logic/sha512_requestor.sv
`timescale 1ns/10ps

module sha512_requestor #(
  parameter int addr_w = 16
)
(
  input  logic               clk,
  input  logic               reset,
  // Job setup from the CSR block
  input  logic               start,
  input  logic [addr_w-1:0]  src_addr,
  input  logic [addr_w-1:0]  block_count,
  // Memory side, Wishbone classic master, read only
  output logic               m_cyc,
  output logic               m_stb,
  output logic [addr_w-1:0]  m_adr,
  input  logic               m_ack,
  input  sha512_pkg::word_t  m_dat_r,
  // Block path into the FIFO
  output logic               push,
  output sha512_pkg::block_t push_block,
  output logic               push_first,
  output logic               push_last,
  input  logic               full
);

  import sha512_pkg::*;

  req_state_t        state;
  logic [3:0]        word_cnt;
  logic [addr_w-1:0] blocks_left;
  logic              first_q;
  logic              beat_done;
  block_t            block_q;

  // One memory word has been returned in this cycle
  assign beat_done = (state == req_read) && m_stb && m_ack;

  // The push waits in its state until the FIFO has room
  assign push       = (state == req_push) && !full;
  assign push_block = block_q;
  assign push_first = first_q;
  assign push_last  = (blocks_left == addr_w'(1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= req_idle;
      m_cyc       <= 1'b0;
      m_stb       <= 1'b0;
      m_adr       <= '0;
      word_cnt    <= '0;
      blocks_left <= '0;
      first_q     <= 1'b0;
    end
    else
    begin
      case (state)
        req_idle:
          if (start)
          begin
            m_adr       <= src_addr;
            blocks_left <= block_count;
            first_q     <= 1'b1;
            word_cnt    <= '0;
            m_cyc       <= 1'b1;
            m_stb       <= 1'b1;
            state       <= req_read;
          end
        req_read:
          if (beat_done)
          begin
            // Strobe drops for a cycle between words
            m_stb    <= 1'b0;
            m_adr    <= m_adr + 1'b1;
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == 4'd15)
            begin
              m_cyc <= 1'b0;
              state <= req_push;
            end
          end
          else if (!m_stb)
            m_stb <= 1'b1;
        req_push:
          if (!full)
          begin
            first_q     <= 1'b0;
            blocks_left <= blocks_left - 1'b1;
            if (push_last)
              state <= req_idle;
            else
            begin
              // Word counter has wrapped to zero for the next block
              m_cyc <= 1'b1;
              m_stb <= 1'b1;
              state <= req_read;
            end
          end
        default:
          state <= req_idle;
      endcase
    end
  end

  // Shift each word in from the bottom, so W0 ends up on top after 16 words
  always_ff @(posedge clk)
  begin
    if (beat_done)
      block_q <= {block_q[959:0], m_dat_r};
  end

endmodule

//--- logic/sha512_csr.sv
`timescale 1ns/10ps

module sha512_csr #(
  parameter int addr_w = 16
)
(
  input  logic                clk,
  input  logic                reset,
  // Host side, Wishbone classic slave
  input  logic                s_cyc,
  input  logic                s_stb,
  input  logic                s_we,
  input  logic [3:0]          s_adr,
  input  sha512_pkg::word_t   s_dat_w,
  output logic                s_ack,
  output sha512_pkg::word_t   s_dat_r,
  // Job setup towards the requestor
  output logic                start,
  output logic [addr_w-1:0]   src_addr,
  output logic [addr_w-1:0]   block_count,
  // Result from the core
  input  sha512_pkg::digest_t digest,
  input  logic                digest_valid
);

  import sha512_pkg::*;

  logic    bus_req;
  logic    wr_en;
  logic    busy;
  logic    done;
  digest_t digest_q;
  word_t   rd_data;

  // A new access is one that has not been acknowledged yet
  assign bus_req = s_cyc && s_stb && !s_ack;
  assign wr_en   = bus_req && s_we;

  // Read mux, offsets without a register read as zero
  always_comb
  begin
    case (s_adr)
      csr_status:      rd_data = {62'b0, done, busy};
      csr_src_addr:    rd_data = word_t'(src_addr);
      csr_block_count: rd_data = word_t'(block_count);
      default:         rd_data = '0;
    endcase
    // The upper half of the map holds the digest, H0 first
    if (s_adr >= csr_digest_base)
      rd_data = digest_q[511 - 64 * 3'(s_adr - csr_digest_base) -: 64];
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      s_ack       <= 1'b0;
      start       <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
      src_addr    <= '0;
      block_count <= '0;
      digest_q    <= '0;
    end
    else
    begin
      s_ack <= bus_req;
      start <= 1'b0;
      // Job setup is frozen while a job runs, so a start while busy is dropped
      if (wr_en && !busy)
      begin
        if (s_adr == csr_ctrl && s_dat_w[0])
        begin
          start <= 1'b1;
          busy  <= 1'b1;
          done  <= 1'b0;
        end
        if (s_adr == csr_src_addr)
          src_addr <= s_dat_w[addr_w-1:0];
        if (s_adr == csr_block_count)
          block_count <= s_dat_w[addr_w-1:0];
      end
      // Last block finished, keep its digest for the host
      if (digest_valid)
      begin
        busy     <= 1'b0;
        done     <= 1'b1;
        digest_q <= digest;
      end
    end
  end

  // Read data is captured on the same edge that raises the acknowledge
  always_ff @(posedge clk)
  begin
    if (bus_req)
      s_dat_r <= rd_data;
  end

endmodule

//--- logic/sha512_pkg.sv
package sha512_pkg;

  // ==============================
  // Data widths
  // ==============================

  // One SHA-512 word, which is also one data beat on the memory bus
  typedef logic [63:0] word_t;

  // One message block of 16 words, W0 in the most significant position
  typedef logic [1023:0] block_t;

  // One hash state of 8 words, H0 in the most significant position
  typedef logic [511:0] digest_t;

  // ==============================
  // FIPS 180-4 constants
  // ==============================

  // Round constants K0 to K79, indexed by the round number
  localparam word_t k_table [80] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // Initial hash value H0 to H7, packed with H0 on top
  localparam digest_t h_init = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  // ==============================
  // Register map, in word offsets
  // ==============================

  localparam logic [3:0] csr_ctrl        = 4'd0;
  localparam logic [3:0] csr_status      = 4'd1;
  localparam logic [3:0] csr_src_addr    = 4'd2;
  localparam logic [3:0] csr_block_count = 4'd3;
  // Digest word i lives at this base plus i
  localparam logic [3:0] csr_digest_base = 4'd8;

  // ==============================
  // State machines
  // ==============================

  typedef enum logic [1:0] {core_idle, core_round, core_finish} core_state_t;

  typedef enum logic [1:0] {req_idle, req_read, req_push} req_state_t;

endpackage
